// ==== logic/shadow_settings.svh ====
// shadow register bank settings
// widths of the one-wire frame and the shadow address map
`ifndef SHADOW_SETTINGS_SVH
`define SHADOW_SETTINGS_SVH

//==================================================
// widths
//==================================================
`define SHADOW_REG_DW   10
`define SHADOW_ADC_DW   10
`define SHADOW_AW       7

// top command bit is the write flag, the rest is the address
`define OWT_CMD_W       8
// two adc words side by side
`define OWT_DATA_W      20

//==================================================
// shadow address map
//==================================================
`define ADDR_EFUSE_CFG  7'h06
`define ADDR_EFUSE_STAT 7'h07
`define ADDR_STATUS1    7'h08
`define ADDR_STATUS2    7'h0A
`define ADDR_STATUS3    7'h0C
`define ADDR_STATUS4    7'h0D
`define ADDR_BIST1      7'h14
`define ADDR_BIST2      7'h15

// one frame here loads both adc shadows
`define ADDR_ADC        7'h1F

`endif

// ==== logic/shadow_pkg.sv ====
// shadow bank types
// vector types for frame and register fields, wishbone cycle states
`include "shadow_settings.svh"

package shadow_pkg;

    //==================================================
    // data and address vectors
    //==================================================
    typedef logic [`SHADOW_REG_DW-1:0] reg_data_t;
    typedef logic [`SHADOW_ADC_DW-1:0] adc_word_t;
    typedef logic [`SHADOW_AW-1:0]     reg_addr_t;

    // raw one-wire receiver fields
    typedef logic [`OWT_CMD_W-1:0]     owt_cmd_t;
    // also the wishbone read data width
    typedef logic [`OWT_DATA_W-1:0]    owt_data_t;

    //==================================================
    // wishbone slave cycle
    //==================================================
    typedef enum logic {
        WB_IDLE,
        WB_RESP
    } wb_state_t;

endpackage

// ==== logic/shadow_wr_if.sv ====
// shadow write interface
// one registered frame write, broadcast from control to the shadow banks
`timescale 1ns/1ps

interface shadow_wr_if import shadow_pkg::*; ();

    // one cycle per accepted frame
    logic      wr_stb;
    reg_addr_t wr_addr;
    adc_word_t wr_lo;
    adc_word_t wr_hi;

    modport ctrl (
        output wr_stb,
        output wr_addr,
        output wr_lo,
        output wr_hi
    );

    // address decode is left to each bank
    modport bank (
        input wr_stb,
        input wr_addr,
        input wr_lo,
        input wr_hi
    );

endinterface

// ==== logic/owt_shadow_ctrl.sv ====
// shadow bank control
// qualifies one-wire frames into shadow writes and runs the wishbone read cycle
`timescale 1ns/1ps
`include "shadow_settings.svh"

module owt_shadow_ctrl import shadow_pkg::*; (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_owt_rx_ack,
    input  owt_cmd_t    i_owt_rx_cmd,
    input  owt_data_t   i_owt_rx_data,
    input  logic        i_owt_rx_status,
    input  logic        i_wb_cyc,
    input  logic        i_wb_stb,
    input  logic        i_wb_we,
    input  reg_addr_t   i_wb_adr,
    output owt_data_t   o_wb_dat,
    output logic        o_wb_ack,
    output logic        o_wb_err,
    shadow_wr_if.ctrl   wr,
    output reg_addr_t   o_rd_addr,
    input  reg_data_t   i_bank_rd_data,
    input  logic        i_bank_rd_hit,
    input  owt_data_t   i_adc_rd_data,
    input  logic        i_adc_rd_hit
);

    logic      frame_ok;
    logic      wb_req;
    logic      wb_we_q;
    logic      rd_hit;
    owt_data_t rd_data;
    wb_state_t state_q;
    wb_state_t state_d;

    //==================================================
    // frame path
    //==================================================
    // rx ack, no error, write flag set
    assign frame_ok = i_owt_rx_ack & ~i_owt_rx_status & i_owt_rx_cmd[`OWT_CMD_W-1];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr.wr_stb <= 1'b0;
        end else begin
            wr.wr_stb <= frame_ok;
        end
    end

    always_ff @(posedge i_clk) begin
        if (frame_ok) begin
            wr.wr_addr <= i_owt_rx_cmd[`SHADOW_AW-1:0];
            wr.wr_lo   <= i_owt_rx_data[`SHADOW_ADC_DW-1:0];
            wr.wr_hi   <= i_owt_rx_data[`OWT_DATA_W-1 -: `SHADOW_ADC_DW];
        end
    end

    //==================================================
    // wishbone slave
    //==================================================
    assign wb_req = i_wb_cyc & i_wb_stb;

    always_comb begin
        state_d = state_q;
        case (state_q)
            WB_IDLE: begin
                if (wb_req) begin
                    state_d = WB_RESP;
                end
            end
            WB_RESP: state_d = WB_IDLE;
            default: state_d = WB_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q <= WB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request fields held for the response cycle
    always_ff @(posedge i_clk) begin
        if (state_q == WB_IDLE && wb_req) begin
            o_rd_addr <= i_wb_adr;
            wb_we_q   <= i_wb_we;
        end
    end

    // banks return zero without a hit, so or-ing is enough
    assign rd_hit  = i_bank_rd_hit | i_adc_rd_hit;
    assign rd_data = {{(`OWT_DATA_W - `SHADOW_REG_DW){1'b0}}, i_bank_rd_data} | i_adc_rd_data;

    assign o_wb_ack = (state_q == WB_RESP) & ~wb_we_q & rd_hit;
    assign o_wb_err = (state_q == WB_RESP) & (wb_we_q | ~rd_hit);
    assign o_wb_dat = o_wb_ack ? rd_data : '0;

endmodule

// ==== logic/status_shadow_bank.sv ====
// status shadow bank
// eight 10-bit copies of the hv status registers, written from qualified frames
`timescale 1ns/1ps
`include "shadow_settings.svh"

module status_shadow_bank import shadow_pkg::*; (
    input  logic        i_clk,
    input  logic        i_reset,
    shadow_wr_if.bank   wr,
    input  reg_addr_t   i_rd_addr,
    output reg_data_t   o_rd_data,
    output logic        o_rd_hit
);

    localparam int NUM_REGS = 8;

    // slot order: efuse cfg/stat, status1..4, bist1/2
    localparam reg_addr_t REG_ADDR [NUM_REGS] = '{
        `ADDR_EFUSE_CFG,
        `ADDR_EFUSE_STAT,
        `ADDR_STATUS1,
        `ADDR_STATUS2,
        `ADDR_STATUS3,
        `ADDR_STATUS4,
        `ADDR_BIST1,
        `ADDR_BIST2
    };

    reg_data_t           shadow [NUM_REGS];
    logic [NUM_REGS-1:0] wr_sel;
    logic [NUM_REGS-1:0] rd_sel;

    //==================================================
    // write decode and storage
    //==================================================
    for (genvar gi = 0; gi < NUM_REGS; gi++) begin : g_reg
        assign wr_sel[gi] = wr.wr_stb && (wr.wr_addr == REG_ADDR[gi]);
        assign rd_sel[gi] = (i_rd_addr == REG_ADDR[gi]);

        always_ff @(posedge i_clk) begin
            if (i_reset) begin
                shadow[gi] <= '0;
            end else if (wr_sel[gi]) begin
                // register value sits in the low half of the frame
                shadow[gi] <= wr.wr_lo;
            end
        end
    end

    //==================================================
    // read select
    //==================================================
    // addresses are distinct, at most one select is set
    always_comb begin
        o_rd_data = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (rd_sel[i]) begin
                o_rd_data = o_rd_data | shadow[i];
            end
        end
    end

    assign o_rd_hit = |rd_sel;

endmodule

// ==== logic/adc_shadow_pair.sv ====
// adc shadow pair
// both adc words loaded from one frame and read back as a single word
`timescale 1ns/1ps
`include "shadow_settings.svh"

module adc_shadow_pair import shadow_pkg::*; (
    input  logic        i_clk,
    input  logic        i_reset,
    shadow_wr_if.bank   wr,
    input  reg_addr_t   i_rd_addr,
    output owt_data_t   o_rd_data,
    output logic        o_rd_hit
);

    adc_word_t adc1;
    adc_word_t adc2;
    logic      wr_hit;

    assign wr_hit = wr.wr_stb && (wr.wr_addr == `ADDR_ADC);

    // adc1 from low half, adc2 from high half, same edge
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            adc1 <= '0;
            adc2 <= '0;
        end else if (wr_hit) begin
            adc1 <= wr.wr_lo;
            adc2 <= wr.wr_hi;
        end
    end

    //==================================================
    // readback
    //==================================================
    assign o_rd_hit  = (i_rd_addr == `ADDR_ADC);
    assign o_rd_data = o_rd_hit ? {adc2, adc1} : '0;

endmodule

// ==== logic/owt_shadow_top.sv ====
// lv shadow register bank
// copies hv registers from one-wire frames, read back over a wishbone slave
`timescale 1ns/1ps

module owt_shadow_top import shadow_pkg::*; (
    input  logic        i_clk,
    input  logic        i_reset,
    // one-wire receiver
    input  logic        i_owt_rx_ack,
    input  owt_cmd_t    i_owt_rx_cmd,
    input  owt_data_t   i_owt_rx_data,
    input  logic        i_owt_rx_status,
    // wishbone classic slave
    input  logic        i_wb_cyc,
    input  logic        i_wb_stb,
    input  logic        i_wb_we,
    input  reg_addr_t   i_wb_adr,
    output owt_data_t   o_wb_dat,
    output logic        o_wb_ack,
    output logic        o_wb_err
);

    reg_addr_t rd_addr;
    reg_data_t bank_rd_data;
    logic      bank_rd_hit;
    owt_data_t adc_rd_data;
    logic      adc_rd_hit;

    shadow_wr_if u_wr_if ();

    //==================================================
    // control
    //==================================================
    owt_shadow_ctrl u_ctrl (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_owt_rx_ack    (i_owt_rx_ack),
        .i_owt_rx_cmd    (i_owt_rx_cmd),
        .i_owt_rx_data   (i_owt_rx_data),
        .i_owt_rx_status (i_owt_rx_status),
        .i_wb_cyc        (i_wb_cyc),
        .i_wb_stb        (i_wb_stb),
        .i_wb_we         (i_wb_we),
        .i_wb_adr        (i_wb_adr),
        .o_wb_dat        (o_wb_dat),
        .o_wb_ack        (o_wb_ack),
        .o_wb_err        (o_wb_err),
        .wr              (u_wr_if.ctrl),
        .o_rd_addr       (rd_addr),
        .i_bank_rd_data  (bank_rd_data),
        .i_bank_rd_hit   (bank_rd_hit),
        .i_adc_rd_data   (adc_rd_data),
        .i_adc_rd_hit    (adc_rd_hit)
    );

    //==================================================
    // shadow banks
    //==================================================
    status_shadow_bank u_status_bank (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .wr        (u_wr_if.bank),
        .i_rd_addr (rd_addr),
        .o_rd_data (bank_rd_data),
        .o_rd_hit  (bank_rd_hit)
    );

    adc_shadow_pair u_adc_pair (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .wr        (u_wr_if.bank),
        .i_rd_addr (rd_addr),
        .o_rd_data (adc_rd_data),
        .o_rd_hit  (adc_rd_hit)
    );

endmodule

// ==== verif/owt_shadow_props.sv ====
// wishbone handshake and write strobe properties
// bound into the shadow bank control
`timescale 1ns/1ps

module owt_shadow_props import shadow_pkg::*; (
    input logic      i_clk,
    input logic      i_reset,
    input logic      i_wb_cyc,
    input logic      i_wb_stb,
    input logic      i_wb_ack,
    input logic      i_wb_err,
    input wb_state_t i_state,
    input logic      i_wr_stb
);

    int fail_count = 0;

    a_ack_err_excl: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_wb_ack && i_wb_err))
    else begin
        fail_count++;
        $error("ack and err high together");
    end

    // one-cycle response
    a_resp_one_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_wb_ack || i_wb_err) |=> !(i_wb_ack || i_wb_err))
    else begin
        fail_count++;
        $error("response held longer than one cycle");
    end

    a_resp_follows_req: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_state == WB_IDLE && i_wb_cyc && i_wb_stb) |=> (i_wb_ack || i_wb_err))
    else begin
        fail_count++;
        $error("no response one cycle after request");
    end

    a_stb_reset: assert property (@(posedge i_clk) i_reset |=> !i_wr_stb)
    else begin
        fail_count++;
        $error("write strobe high during reset");
    end

endmodule

bind owt_shadow_ctrl owt_shadow_props u_props (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_wb_cyc (i_wb_cyc),
    .i_wb_stb (i_wb_stb),
    .i_wb_ack (o_wb_ack),
    .i_wb_err (o_wb_err),
    .i_state  (state_q),
    .i_wr_stb (wr.wr_stb)
);

// ==== verif/owt_shadow_tb.sv ====
// shadow register bank testbench
// table-driven frames and wishbone reads, checked against a reference model
`timescale 1ns/1ps
`include "shadow_settings.svh"

module owt_shadow_tb import shadow_pkg::*; ();

    localparam int RESET_CYCLES = 4;
    localparam int MAX_ROWS     = 128;
    localparam int NUM_MAPPED   = 9;
    localparam reg_addr_t MAP_ADDR [NUM_MAPPED] = '{
        `ADDR_EFUSE_CFG, `ADDR_EFUSE_STAT, `ADDR_STATUS1, `ADDR_STATUS2,
        `ADDR_STATUS3, `ADDR_STATUS4, `ADDR_BIST1, `ADDR_BIST2, `ADDR_ADC
    };

    typedef struct packed {
        logic      is_read;
        logic      rx_ack;
        logic      rx_status;
        owt_cmd_t  cmd;
        owt_data_t data;
        logic      we;
        reg_addr_t adr;
        logic      back2back;
        owt_data_t exp_data;
        logic      exp_err;
    } row_t;

    logic      i_clk;
    logic      i_reset;
    logic      i_owt_rx_ack;
    owt_cmd_t  i_owt_rx_cmd;
    owt_data_t i_owt_rx_data;
    logic      i_owt_rx_status;
    logic      i_wb_cyc;
    logic      i_wb_stb;
    logic      i_wb_we;
    reg_addr_t i_wb_adr;
    owt_data_t o_wb_dat;
    logic      o_wb_ack;
    logic      o_wb_err;

    row_t        rows [MAX_ROWS];
    string       row_name [MAX_ROWS];
    owt_data_t   ref_mem [128];
    int          num_rows = 0;
    int          error_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = MAX_ROWS * 8 + RESET_CYCLES;
    logic [31:0] rng = 32'd41114;

    owt_shadow_top DUT (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_owt_rx_ack    (i_owt_rx_ack),
        .i_owt_rx_cmd    (i_owt_rx_cmd),
        .i_owt_rx_data   (i_owt_rx_data),
        .i_owt_rx_status (i_owt_rx_status),
        .i_wb_cyc        (i_wb_cyc),
        .i_wb_stb        (i_wb_stb),
        .i_wb_we         (i_wb_we),
        .i_wb_adr        (i_wb_adr),
        .o_wb_dat        (o_wb_dat),
        .o_wb_ack        (o_wb_ack),
        .o_wb_err        (o_wb_err)
    );

    always #20 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout, table not finished after %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic is_mapped(input reg_addr_t a);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < NUM_MAPPED; i++) begin
            if (a == MAP_ADDR[i]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    //==================================================
    // table and reference model
    //==================================================
    task automatic add_frame(input string name, input logic ack, input logic status,
                             input owt_cmd_t cmd, input owt_data_t data, input logic b2b);
        reg_addr_t a;
        a = cmd[`SHADOW_AW-1:0];
        rows[num_rows] = '0;
        rows[num_rows].rx_ack    = ack;
        rows[num_rows].rx_status = status;
        rows[num_rows].cmd       = cmd;
        rows[num_rows].data      = data;
        rows[num_rows].back2back = b2b;
        row_name[num_rows] = name;
        num_rows++;
        // status shadows keep only the low half, adc takes the whole frame
        if (ack && !status && cmd[`OWT_CMD_W-1] && is_mapped(a)) begin
            if (a == `ADDR_ADC) begin
                ref_mem[a] = data;
            end else begin
                ref_mem[a] = owt_data_t'(data[`SHADOW_REG_DW-1:0]);
            end
        end
    endtask

    task automatic add_read(input string name, input reg_addr_t adr, input logic we);
        rows[num_rows] = '0;
        rows[num_rows].is_read  = 1'b1;
        rows[num_rows].we       = we;
        rows[num_rows].adr      = adr;
        rows[num_rows].exp_err  = we || !is_mapped(adr);
        rows[num_rows].exp_data = (we || !is_mapped(adr)) ? '0 : ref_mem[adr];
        row_name[num_rows] = name;
        num_rows++;
    endtask

    task automatic build_table();
        owt_data_t d;
        reg_addr_t a;
        int        idx;
        for (int i = 0; i < NUM_MAPPED; i++) begin
            add_read($sformatf("reset_read_%h", MAP_ADDR[i]), MAP_ADDR[i], 1'b0);
        end
        // high half set so that it must be dropped
        for (int i = 0; i < NUM_MAPPED - 1; i++) begin
            d = {10'h3FF, 10'(i * 73 + 19)};
            add_frame($sformatf("status_frame_%h", MAP_ADDR[i]), 1'b1, 1'b0,
                      {1'b1, MAP_ADDR[i]}, d, 1'b0);
        end
        for (int i = 0; i < NUM_MAPPED - 1; i++) begin
            add_read($sformatf("status_read_%h", MAP_ADDR[i]), MAP_ADDR[i], 1'b0);
        end
        add_frame("bad_status", 1'b1, 1'b1, {1'b1, `ADDR_STATUS1}, 20'h00155, 1'b0);
        add_frame("bad_ack", 1'b0, 1'b0, {1'b1, `ADDR_STATUS1}, 20'h002AA, 1'b0);
        add_frame("bad_flag", 1'b1, 1'b0, {1'b0, `ADDR_STATUS1}, 20'h00333, 1'b0);
        add_frame("bad_flag_adc", 1'b1, 1'b0, {1'b0, `ADDR_ADC}, 20'hFFFFF, 1'b0);
        add_read("bad_read_status1", `ADDR_STATUS1, 1'b0);
        add_read("bad_read_adc", `ADDR_ADC, 1'b0);
        add_frame("adc_frame", 1'b1, 1'b0, {1'b1, `ADDR_ADC}, 20'h9E3C7, 1'b0);
        add_read("adc_read", `ADDR_ADC, 1'b0);
        add_read("wb_write_status1", `ADDR_STATUS1, 1'b1);
        add_read("unmapped_09", 7'h09, 1'b0);
        add_read("wb_write_adc", `ADDR_ADC, 1'b1);
        add_read("unmapped_7f", 7'h7F, 1'b0);
        // frames on consecutive cycles, last one wins
        add_frame("b2b_first", 1'b1, 1'b0, {1'b1, `ADDR_STATUS2}, 20'h00111, 1'b1);
        add_frame("b2b_second", 1'b1, 1'b0, {1'b1, `ADDR_STATUS2}, 20'h00222, 1'b1);
        add_frame("b2b_adc", 1'b1, 1'b0, {1'b1, `ADDR_ADC}, 20'h5A5A5, 1'b0);
        add_read("b2b_read_status2", `ADDR_STATUS2, 1'b0);
        add_read("b2b_read_adc", `ADDR_ADC, 1'b0);
        for (int k = 0; k < 48; k++) begin
            rng = xorshift32(rng);
            idx = int'(rng[5:2]) % 10;
            a = (idx < NUM_MAPPED) ? MAP_ADDR[idx] : rng[18:12];
            if (rng[1:0] == 2'b00) begin
                add_read($sformatf("random_read_%0d", k), a, rng[15:13] == 3'b000);
            end else begin
                add_frame($sformatf("random_frame_%0d", k), rng[6] | rng[7],
                          rng[9:8] == 2'b00, {rng[10] | rng[11], a}, rng[31:12], 1'b0);
            end
        end
        for (int i = 0; i < NUM_MAPPED; i++) begin
            add_read($sformatf("final_read_%h", MAP_ADDR[i]), MAP_ADDR[i], 1'b0);
        end
    endtask

    //==================================================
    // compare tasks and row drivers
    //==================================================
    task automatic check_data(input string name, input owt_data_t exp, input owt_data_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, got %h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, got %b", name, exp, act);
            error_count++;
        end
    endtask

    task automatic run_frame(input int r);
        @(posedge i_clk);
        #1;
        i_owt_rx_ack    = rows[r].rx_ack;
        i_owt_rx_status = rows[r].rx_status;
        i_owt_rx_cmd    = rows[r].cmd;
        i_owt_rx_data   = rows[r].data;
        if (!rows[r].back2back) begin
            @(posedge i_clk);
            #1;
            i_owt_rx_ack    = 1'b0;
            i_owt_rx_status = 1'b0;
            i_owt_rx_cmd    = '0;
            i_owt_rx_data   = '0;
        end
    endtask

    task automatic run_read(input int r);
        int   waited;
        logic got;
        waited = 0;
        got = 1'b0;
        @(posedge i_clk);
        #1;
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = rows[r].we;
        i_wb_adr = rows[r].adr;
        while (!got && waited < 4) begin
            @(negedge i_clk);
            waited++;
            got = o_wb_ack | o_wb_err;
        end
        if (got) begin
            check_err({row_name[r], " err"}, rows[r].exp_err, o_wb_err);
            check_err({row_name[r], " ack"}, ~rows[r].exp_err, o_wb_ack);
            check_data(row_name[r], rows[r].exp_data, o_wb_dat);
        end else begin
            $display("%s: no ack or err from the wishbone slave within 4 cycles", row_name[r]);
            error_count++;
        end
        @(posedge i_clk);
        #1;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        i_wb_adr = '0;
    endtask

    //==================================================
    // main sequence
    //==================================================
    initial begin
        i_clk           = 1'b0;
        i_reset         = 1'b1;
        i_owt_rx_ack    = 1'b0;
        i_owt_rx_cmd    = '0;
        i_owt_rx_data   = '0;
        i_owt_rx_status = 1'b0;
        i_wb_cyc        = 1'b0;
        i_wb_stb        = 1'b0;
        i_wb_we         = 1'b0;
        i_wb_adr        = '0;
        for (int a = 0; a < 128; a++) begin
            ref_mem[a] = '0;
        end
        build_table();
        cycle_limit = num_rows * 8 + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        for (int r = 0; r < num_rows; r++) begin
            if (rows[r].is_read) begin
                run_read(r);
            end else begin
                run_frame(r);
            end
        end
        repeat (2) @(posedge i_clk);
        $display("rows: %0d, check errors: %0d, assertion failures: %0d",
                 num_rows, error_count, DUT.u_ctrl.u_props.fail_count);
        if (error_count == 0 && DUT.u_ctrl.u_props.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+logic
logic/shadow_pkg.sv
logic/shadow_wr_if.sv
logic/owt_shadow_ctrl.sv
logic/status_shadow_bank.sv
logic/adc_shadow_pair.sv
logic/owt_shadow_top.sv
verif/owt_shadow_props.sv
verif/owt_shadow_tb.sv

// ==== Makefile ====
# Verilator flow for the shadow register bank

VERILATOR ?= verilator
TOP       := owt_shadow_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
FLAGS     := --timing --assert
PASS_MSG  := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only if the pass line shows up in the simulation output
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
